//--- bench/fw_tb_model.svh
  // Forward weighting reference model
`ifndef FW_TB_MODEL_SVH
`define FW_TB_MODEL_SVH

  ////////////////////////////////////////
  // Random source
  ////////////////////////////////////////

  // Generator state, fixed seed
  logic [31:0] lcg_state = 32'd95;

  // One step of a 32-bit linear congruential generator
  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Next data word, taken from the upper bits
  function automatic data_t rand_word();
    lcg_state = lcg_step(lcg_state);
    return data_t'(lcg_state >> 16);
  endfunction

  // Next value in the range 0 to limit-1
  function automatic int rand_below(input int limit);
    lcg_state = lcg_step(lcg_state);
    return int'(lcg_state[30:16]) % limit;
  endfunction

  ////////////////////////////////////////
  // Reference result
  ////////////////////////////////////////

  // f(i;j) = sum over g of L(g;j) * w(i;g), modulo 2 to the DATA_SIZE
  function automatic data_t expected_f(input int i, input int j, input int n);
    logic [63:0] sum;
    sum = '0;
    // Full precision first
    for (int g = 0; g < n; g++) begin
      sum = sum + 64'(l_mat[g][j]) * 64'(w_mat[i][g]);
    end
    // Then the wrap
    sum = sum % (64'd1 << DATA_SIZE);
    return data_t'(sum);
  endfunction

`endif

//--- bench/fw_tb.sv
// Forward weighting testbench
`default_nettype none
`timescale 1ns/100ps

module fw_tb
  import fw_pkg::*;
();

  ////////////////////////////////////////
  // DUT signals
  ////////////////////////////////////////

  logic  clk;
  logic  reset;
  logic  start;
  logic  ready;
  idx_t  size_n_in;
  idx_t  size_r_in;
  logic  l_in_g_enable;
  logic  l_in_j_enable;
  logic  w_in_i_enable;
  logic  w_in_j_enable;
  data_t l_in;
  data_t w_in;
  logic  f_out_i_enable;
  logic  f_out_j_enable;
  data_t f_out;

  // Operands as sent to the DUT
  data_t l_mat [MAX_N][MAX_N];
  data_t w_mat [MAX_R][MAX_N];

  `include "fw_tb_model.svh"

  // Results still owed by the DUT, in i, j order
  data_t exp_val_q [$];
  int    exp_i_q [$];
  int    exp_j_q [$];

  // Bookkeeping
  string cur_test;
  int    result_errors = 0;
  int    result_checks = 0;
  int    results_seen = 0;
  int    seq_errors = 0;
  int    seq_checks = 0;
  int    test_err_base = 0;
  int    tests_run = 0;
  int    tests_failed = 0;
  int    seen_base = 0;
  logic  timed_out = 1'b0;
  data_t exp_val;
  int    exp_i;
  int    exp_j;

  dnc_forward_weighting #(
    .DATA_SIZE(DATA_SIZE),
    .MAX_N(MAX_N),
    .MAX_R(MAX_R)
  ) i_dnc_forward_weighting (
    .clk(clk),
    .reset(reset),
    .start(start),
    .ready(ready),
    .size_n_in(size_n_in),
    .size_r_in(size_r_in),
    .l_in_g_enable(l_in_g_enable),
    .l_in_j_enable(l_in_j_enable),
    .w_in_i_enable(w_in_i_enable),
    .w_in_j_enable(w_in_j_enable),
    .l_in(l_in),
    .w_in(w_in),
    .f_out_i_enable(f_out_i_enable),
    .f_out_j_enable(f_out_j_enable),
    .f_out(f_out)
  );

  // 100 ns period
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////
  // Result comparison
  ////////////////////////////////////////

  // Outputs change on the rising edge, so look on the falling one
  always @(negedge clk) begin
    if (!reset && f_out_j_enable) begin
      // Every strobe counts, pending or not
      results_seen++;
      result_checks++;
      assert (exp_val_q.size() != 0) else begin
        result_errors++;
        $display("result strobe in %s with no result pending", cur_test);
      end
      if (exp_val_q.size() != 0) begin
        exp_val = exp_val_q.pop_front();
        exp_i = exp_i_q.pop_front();
        exp_j = exp_j_q.pop_front();
        result_checks += 2;
        assert (f_out == exp_val) else begin
          result_errors++;
          $display("FAIL %s f(%0d;%0d) expected %h actual %h",
                   cur_test, exp_i, exp_j, exp_val, f_out);
        end
        // Head strobe only with the first slot
        assert (f_out_i_enable == (exp_j == 0)) else begin
          result_errors++;
          $display("FAIL %s head strobe at f(%0d;%0d) expected %0b actual %0b",
                   cur_test, exp_i, exp_j, exp_j == 0, f_out_i_enable);
        end
      end
    end else if (!reset) begin
      assert (!f_out_i_enable) else begin
        result_errors++;
        $display("head strobe without a result strobe in %s", cur_test);
      end
    end
  end

  ////////////////////////////////////////
  // Test helpers
  ////////////////////////////////////////

  task automatic begin_test(input string name);
    cur_test = name;
    test_err_base = result_errors + seq_errors;
  endtask

  // One line per test
  task automatic end_test();
    int errs;
    errs = result_errors + seq_errors - test_err_base;
    tests_run++;
    if (errs == 0 && !timed_out) begin
      $display("%s: ok", cur_test);
    end else begin
      tests_failed++;
      $display("%s: %0d errors%s", cur_test, errs, timed_out ? ", timed out" : "");
    end
  endtask

  task automatic wait_ready(input int limit);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!ready && !timed_out) begin
      if (cycles >= limit) begin
        timed_out = 1'b1;
        $display("timeout in %s, ready stayed low for %0d cycles", cur_test, limit);
      end else begin
        cycles++;
        @(negedge clk);
      end
    end
  endtask

  task automatic wait_results(input int limit);
    int cycles;
    cycles = 0;
    while (exp_val_q.size() != 0 && !timed_out) begin
      if (cycles >= limit) begin
        timed_out = 1'b1;
        $display("timeout in %s, %0d results never came", cur_test, exp_val_q.size());
      end else begin
        cycles++;
        @(negedge clk);
      end
    end
  endtask

  function automatic void fill_random();
    for (int a = 0; a < MAX_N; a++) begin
      for (int b = 0; b < MAX_N; b++) begin
        l_mat[a][b] = rand_word();
      end
    end
    for (int a = 0; a < MAX_R; a++) begin
      for (int b = 0; b < MAX_N; b++) begin
        w_mat[a][b] = rand_word();
      end
    end
  endfunction

  function automatic void fill_identity_l();
    for (int a = 0; a < MAX_N; a++) begin
      for (int b = 0; b < MAX_N; b++) begin
        l_mat[a][b] = (a == b) ? data_t'(1) : '0;
      end
    end
  endfunction

  function automatic void fill_ones();
    for (int a = 0; a < MAX_N; a++) begin
      for (int b = 0; b < MAX_N; b++) begin
        l_mat[a][b] = '1;
        if (a < MAX_R) begin
          w_mat[a][b] = '1;
        end
      end
    end
  endfunction

  function automatic void queue_expected(input int n, input int r);
    for (int i = 0; i < r; i++) begin
      for (int j = 0; j < n; j++) begin
        exp_val_q.push_back(expected_f(i, j, n));
        exp_i_q.push_back(i);
        exp_j_q.push_back(j);
      end
    end
  endfunction

  // L row by row, w head by head, with optional random gaps
  task automatic stream_operands(input int n, input int r, input bit interleave,
                                 input int max_gap);
    int l_pos;
    int w_pos;
    int l_gap;
    int w_gap;
    bit l_busy;
    l_pos = 0;
    w_pos = 0;
    l_gap = 0;
    w_gap = 0;
    while (l_pos < n * n || w_pos < r * n) begin
      @(posedge clk);
      l_busy = (l_pos < n * n);
      l_in_g_enable <= 1'b0;
      l_in_j_enable <= 1'b0;
      w_in_i_enable <= 1'b0;
      w_in_j_enable <= 1'b0;
      if (l_busy) begin
        if (l_gap > 0) begin
          l_gap--;
        end else begin
          l_in <= l_mat[l_pos / n][l_pos % n];
          l_in_j_enable <= 1'b1;
          l_in_g_enable <= (l_pos % n == 0);
          l_pos++;
          l_gap = rand_below(max_gap + 1);
        end
      end
      // Without interleave w waits for the end of L
      if (w_pos < r * n && (interleave || !l_busy)) begin
        if (w_gap > 0) begin
          w_gap--;
        end else begin
          w_in <= w_mat[w_pos / n][w_pos % n];
          w_in_j_enable <= 1'b1;
          w_in_i_enable <= (w_pos % n == 0);
          w_pos++;
          w_gap = rand_below(max_gap + 1);
        end
      end
    end
    @(posedge clk);
    l_in_g_enable <= 1'b0;
    l_in_j_enable <= 1'b0;
    w_in_i_enable <= 1'b0;
    w_in_j_enable <= 1'b0;
  endtask

  // Full run from start until ready again
  task automatic run_case(input int n, input int r, input bit interleave, input int max_gap);
    if (timed_out) begin
      return;
    end
    wait_ready(200);
    if (timed_out) begin
      return;
    end
    queue_expected(n, r);
    @(posedge clk);
    start <= 1'b1;
    size_n_in <= idx_t'(n);
    size_r_in <= idx_t'(r);
    @(posedge clk);
    start <= 1'b0;
    stream_operands(n, r, interleave, max_gap);
    wait_results(4000);
    if (timed_out) begin
      return;
    end
    wait_ready(200);
    // Quiet tail where stray strobes reach the checker
    repeat (4) @(negedge clk);
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    // Every input idle
    reset <= 1'b1;
    start <= 1'b0;
    size_n_in <= idx_t'(MAX_N);
    size_r_in <= idx_t'(MAX_R);
    l_in_g_enable <= 1'b0;
    l_in_j_enable <= 1'b0;
    w_in_i_enable <= 1'b0;
    w_in_j_enable <= 1'b0;
    l_in <= '0;
    w_in <= '0;
    cur_test = "reset";
    repeat (16) @(posedge clk);
    reset <= 1'b0;

    begin_test("reset_idle");
    repeat (20) begin
      @(negedge clk);
      seq_checks += 2;
      assert (ready) else begin
        seq_errors++;
        $display("ready is low in %s while idle after reset", cur_test);
      end
      assert (!f_out_j_enable && !f_out_i_enable) else begin
        seq_errors++;
        $display("result strobe in %s before any start", cur_test);
      end
    end
    end_test();

    // Identity L gives f equal to w
    begin_test("identity_l");
    fill_random();
    fill_identity_l();
    run_case(MAX_N, MAX_R, 1'b0, 0);
    end_test();

    begin_test("random_full");
    fill_random();
    run_case(MAX_N, MAX_R, 1'b0, 0);
    end_test();

    // Run-time sizes below the limits
    begin_test("small_sizes");
    fill_random();
    seen_base = results_seen;
    run_case(3, 2, 1'b1, 1);
    seq_checks += 2;
    assert (results_seen - seen_base == 6) else begin
      seq_errors++;
      $display("FAIL %s result count expected %0d actual %0d",
               cur_test, 6, results_seen - seen_base);
    end
    assert (ready) else begin
      seq_errors++;
      $display("ready did not return high after %s", cur_test);
    end
    end_test();

    // Every product is one after the wrap
    begin_test("all_ones_wrap");
    fill_ones();
    run_case(MAX_N, MAX_R, 1'b0, 0);
    end_test();

    begin_test("back_to_back");
    fill_random();
    run_case(MAX_N, MAX_R, 1'b1, 3);
    fill_random();
    run_case(6, 3, 1'b1, 2);
    end_test();

    $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, result_checks + seq_checks,
             result_errors + seq_errors);
    if (result_errors + seq_errors == 0 && !timed_out) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the forward weighting testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --assert -j 0 --top-module fw_tb -f sim.f > build.log 2>&1 \
  || { cat build.log; echo "build error"; exit 1; }

./obj_dir/Vfw_tb > sim.log 2>&1 \
  || { cat sim.log; echo "simulation aborted"; exit 1; }

cat sim.log
grep -q "test failed" sim.log && { echo "simulation reported failure"; exit 1; }
exit 0

//--- sim.f
+incdir+bench
src/fw_pkg.sv
src/fw_index_loader.sv
src/fw_operand_buffer.sv
src/fw_product_engine.sv
src/dnc_forward_weighting.sv
bench/fw_tb.sv

//--- src/dnc_forward_weighting.sv
// DNC forward weighting top level
`default_nettype none
`timescale 1ns/100ps

module dnc_forward_weighting
  import fw_pkg::*;
#(
  parameter int unsigned DATA_SIZE = fw_pkg::DATA_SIZE,
  parameter int unsigned MAX_N = fw_pkg::MAX_N,
  parameter int unsigned MAX_R = fw_pkg::MAX_R
) (
  // Global
  input  logic  clk,
  input  logic  reset,

  // Control
  input  logic  start,
  output logic  ready,
  input  idx_t  size_n_in,
  input  idx_t  size_r_in,

  // L stream, g outer and j inner
  input  logic  l_in_g_enable,
  input  logic  l_in_j_enable,
  // w stream, i outer and g inner
  input  logic  w_in_i_enable,
  input  logic  w_in_j_enable,
  input  data_t l_in,
  input  data_t w_in,

  // f results, i outer and j inner
  output logic  f_out_i_enable,
  output logic  f_out_j_enable,
  output data_t f_out
);

  ////////////////////////////////////////
  // Internal nets
  ////////////////////////////////////////

  // Loader to store
  logic  l_wr_enable;
  addr_t l_wr_addr;
  data_t l_wr_data;
  logic  w_wr_enable;
  addr_t w_wr_addr;
  data_t w_wr_data;

  // Loader to engine
  logic  l_load_done;
  logic  w_load_done;

  // Engine to store and back
  addr_t l_rd_addr;
  addr_t w_rd_addr;
  data_t l_rd_data;
  data_t w_rd_data;

  ////////////////////////////////////////
  // Loaders
  ////////////////////////////////////////

  // L is square, N by N
  fw_index_loader #(
    .MAX_N(MAX_N)
  ) l_loader (
    .clk(clk),
    .reset(reset),
    .start(start),
    .size_rows(size_n_in),
    .size_cols(size_n_in),
    .row_enable(l_in_g_enable),
    .col_enable(l_in_j_enable),
    .data_in(l_in),
    .wr_enable(l_wr_enable),
    .wr_addr(l_wr_addr),
    .wr_data(l_wr_data),
    .load_done(l_load_done)
  );

  // w is R heads by N slots
  fw_index_loader #(
    .MAX_N(MAX_N)
  ) w_loader (
    .clk(clk),
    .reset(reset),
    .start(start),
    .size_rows(size_r_in),
    .size_cols(size_n_in),
    .row_enable(w_in_i_enable),
    .col_enable(w_in_j_enable),
    .data_in(w_in),
    .wr_enable(w_wr_enable),
    .wr_addr(w_wr_addr),
    .wr_data(w_wr_data),
    .load_done(w_load_done)
  );

  ////////////////////////////////////////
  // Stores
  ////////////////////////////////////////

  fw_operand_buffer #(
    .DATA_SIZE(DATA_SIZE),
    .MAX_N(MAX_N)
  ) l_store (
    .clk(clk),
    .wr_enable(l_wr_enable),
    .wr_addr(l_wr_addr),
    .wr_data(l_wr_data),
    .rd_addr(l_rd_addr),
    .rd_data(l_rd_data)
  );

  fw_operand_buffer #(
    .DATA_SIZE(DATA_SIZE),
    .MAX_N(MAX_N)
  ) w_store (
    .clk(clk),
    .wr_enable(w_wr_enable),
    .wr_addr(w_wr_addr),
    .wr_data(w_wr_data),
    .rd_addr(w_rd_addr),
    .rd_data(w_rd_data)
  );

  ////////////////////////////////////////
  // Engine
  ////////////////////////////////////////

  // f(i;j) = sum over g of L(g;j) * w(i;g)
  fw_product_engine #(
    .DATA_SIZE(DATA_SIZE),
    .MAX_N(MAX_N),
    .MAX_R(MAX_R)
  ) product_engine (
    .clk(clk),
    .reset(reset),
    .start(start),
    .size_n(size_n_in),
    .size_r(size_r_in),
    .l_done(l_load_done),
    .w_done(w_load_done),
    .l_rd_addr(l_rd_addr),
    .w_rd_addr(w_rd_addr),
    .l_rd_data(l_rd_data),
    .w_rd_data(w_rd_data),
    .ready(ready),
    .f_out(f_out),
    .f_out_i_enable(f_out_i_enable),
    .f_out_j_enable(f_out_j_enable)
  );

endmodule

`default_nettype wire

//--- src/fw_index_loader.sv
// Operand index loader
`default_nettype none
`timescale 1ns/100ps

module fw_index_loader
  import fw_pkg::*;
#(
  parameter int unsigned MAX_N = fw_pkg::MAX_N
) (
  input  logic  clk,
  input  logic  reset,
  input  logic  start,
  input  idx_t  size_rows,
  input  idx_t  size_cols,
  input  logic  row_enable,
  input  logic  col_enable,
  input  data_t data_in,
  output logic  wr_enable,
  output addr_t wr_addr,
  output data_t wr_data,
  output logic  load_done
);

  ////////////////////////////////////////
  // Position tracking
  ////////////////////////////////////////

  // Position of the next expected element
  idx_t row_q;
  idx_t col_q;

  // Position of the element on the bus this cycle
  idx_t cur_row;
  idx_t cur_col;
  logic cur_last_col;
  logic cur_last;

  always_comb begin
    cur_row = row_q;
    cur_col = col_q;
    // Row strobe always marks column zero
    if (row_enable) begin
      cur_col = '0;
      // Short row seen, so move on to the next one
      if (col_q != '0) begin
        cur_row = idx_t'(row_q + idx_t'(1));
      end
    end
  end

  assign cur_last_col = fw_is_last(cur_col, size_cols);
  assign cur_last = cur_last_col && fw_is_last(cur_row, size_rows);

  always_ff @(posedge clk) begin
    if (reset || start) begin
      row_q <= '0;
      col_q <= '0;
    end else if (col_enable) begin
      // Column wraps at size_cols and carries into the row
      if (cur_last_col) begin
        col_q <= '0;
        row_q <= idx_t'(cur_row + idx_t'(1));
      end else begin
        col_q <= idx_t'(cur_col + idx_t'(1));
        row_q <= cur_row;
      end
    end
  end

  ////////////////////////////////////////
  // Store write port
  ////////////////////////////////////////

  // Write goes out in the same cycle as the strobe
  assign wr_enable = col_enable;
  assign wr_addr = fw_addr(cur_row, cur_col, MAX_N);
  assign wr_data = data_in;

  // Level that holds until the next start
  always_ff @(posedge clk) begin
    if (reset || start) begin
      load_done <= 1'b0;
    end else if (col_enable && cur_last) begin
      load_done <= 1'b1;
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Row strobe only comes with an element
  row_with_col_a : assert property (
    @(posedge clk) disable iff (reset) row_enable |-> col_enable
  );

endmodule

`default_nettype wire

//--- src/fw_operand_buffer.sv
// Operand matrix store
`default_nettype none
`timescale 1ns/100ps

module fw_operand_buffer
  import fw_pkg::*;
#(
  parameter int unsigned DATA_SIZE = fw_pkg::DATA_SIZE,
  parameter int unsigned MAX_N = fw_pkg::MAX_N
) (
  input  logic  clk,
  input  logic  wr_enable,
  input  addr_t wr_addr,
  input  data_t wr_data,
  input  addr_t rd_addr,
  output data_t rd_data
);

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  // Full square; the w store fills only its first MAX_R rows
  localparam int unsigned DEPTH = MAX_N * MAX_N;

  logic [DATA_SIZE-1:0] mem [DEPTH];

  // Single write port, visible after the edge
  always_ff @(posedge clk) begin
    if (wr_enable) begin
      mem[wr_addr] <= wr_data;
    end
  end

  ////////////////////////////////////////
  // Read port
  ////////////////////////////////////////

  // Registered read, one cycle of latency
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Loader position must stay inside the store
  wr_in_range_a : assert property (
    @(posedge clk) wr_enable |-> (int'(wr_addr) < DEPTH)
  );

  // Engine reads only inside the store as well
  rd_in_range_a : assert property (
    @(posedge clk) !$isunknown(rd_addr) |-> (int'(rd_addr) < DEPTH)
  );

endmodule

`default_nettype wire

//--- src/fw_pkg.sv
// Forward weighting shared definitions
`default_nettype none

package fw_pkg;

  ////////////////////////////////////////
  // Size limits
  ////////////////////////////////////////

  // Width of every data word
  localparam int unsigned DATA_SIZE = 16;
  // Largest memory size N
  localparam int unsigned MAX_N = 8;
  // Largest number of read heads R
  localparam int unsigned MAX_R = 4;

  // Index must also hold MAX_N itself as a size
  localparam int unsigned IDX_WIDTH = $clog2(MAX_N + 1);
  localparam int unsigned ADDR_WIDTH = $clog2(MAX_N * MAX_N);

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////

  typedef logic [DATA_SIZE-1:0] data_t;
  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [IDX_WIDTH-1:0] idx_t;

  ////////////////////////////////////////
  // Address helpers
  ////////////////////////////////////////

  // Linear store address, row major with a fixed row stride
  function automatic addr_t fw_addr(idx_t row, idx_t col, int unsigned stride);
    return addr_t'(32'(row) * stride + 32'(col));
  endfunction

  // True on the last position of a run of the given size
  function automatic logic fw_is_last(idx_t idx, idx_t size);
    return idx == idx_t'(size - idx_t'(1));
  endfunction

endpackage

`default_nettype wire

//--- src/fw_product_engine.sv
// Forward weighting product engine
`default_nettype none
`timescale 1ns/100ps

module fw_product_engine
  import fw_pkg::*;
#(
  parameter int unsigned DATA_SIZE = fw_pkg::DATA_SIZE,
  parameter int unsigned MAX_N = fw_pkg::MAX_N,
  parameter int unsigned MAX_R = fw_pkg::MAX_R
) (
  input  logic  clk,
  input  logic  reset,
  input  logic  start,
  input  idx_t  size_n,
  input  idx_t  size_r,
  input  logic  l_done,
  input  logic  w_done,
  output addr_t l_rd_addr,
  output addr_t w_rd_addr,
  input  data_t l_rd_data,
  input  data_t w_rd_data,
  output logic  ready,
  output data_t f_out,
  output logic  f_out_i_enable,
  output logic  f_out_j_enable
);

  ////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    S_IDLE,
    S_WAIT,
    S_COMPUTE
  } state_t;

  state_t state;

  // Head, slot and sum counters
  idx_t i_q;
  idx_t j_q;
  idx_t g_q;
  logic issue_done;
  logic issue;
  logic last_g;
  logic last_j;
  logic last_i;
  logic f_last;

  assign issue = (state == S_COMPUTE) && !issue_done;
  assign last_g = fw_is_last(g_q, size_n);
  assign last_j = fw_is_last(j_q, size_n);
  assign last_i = fw_is_last(i_q, size_r);
  assign ready = (state == S_IDLE);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= S_IDLE;
      issue_done <= 1'b0;
      i_q <= '0;
      j_q <= '0;
      g_q <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (start) begin
            state <= S_WAIT;
          end
        end
        S_WAIT: begin
          // Both operands stored, start at f(0;0)
          if (l_done && w_done) begin
            state <= S_COMPUTE;
            issue_done <= 1'b0;
            i_q <= '0;
            j_q <= '0;
            g_q <= '0;
          end
        end
        S_COMPUTE: begin
          if (issue) begin
            // g inner, j middle, i outer
            g_q <= last_g ? '0 : idx_t'(g_q + idx_t'(1));
            if (last_g) begin
              j_q <= last_j ? '0 : idx_t'(j_q + idx_t'(1));
              if (last_j) begin
                i_q <= idx_t'(i_q + idx_t'(1));
                if (last_i) begin
                  issue_done <= 1'b1;
                end
              end
            end
          end
          // Leave once the final result is on the output
          if (f_out_j_enable && f_last) begin
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // L(g;j) and w(i;g) read every issue cycle
  assign l_rd_addr = fw_addr(g_q, j_q, MAX_N);
  assign w_rd_addr = fw_addr(i_q, g_q, MAX_N);

  ////////////////////////////////////////
  // Read stage tags
  ////////////////////////////////////////

  logic s1_valid;
  logic s1_first_g;
  logic s1_last_g;
  logic s1_first_j;
  logic s1_last;

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= issue;
    end
  end

  // Travel alongside rd_data
  always_ff @(posedge clk) begin
    s1_first_g <= (g_q == '0);
    s1_last_g <= last_g;
    s1_first_j <= (j_q == '0);
    s1_last <= last_g && last_j && last_i;
  end

  ////////////////////////////////////////
  // Multiply accumulate
  ////////////////////////////////////////

  // Low word of the product is all the wrapping sum needs
  logic [DATA_SIZE-1:0] prod;
  data_t acc;

  assign prod = l_rd_data * w_rd_data;

  // Sums wrap at the word width
  always_ff @(posedge clk) begin
    if (s1_valid) begin
      acc <= s1_first_g ? prod : acc + prod;
    end
  end

  // Strobes line up with the finished sum
  always_ff @(posedge clk) begin
    if (reset) begin
      f_out_j_enable <= 1'b0;
      f_out_i_enable <= 1'b0;
      f_last <= 1'b0;
    end else begin
      f_out_j_enable <= s1_valid && s1_last_g;
      f_out_i_enable <= s1_valid && s1_last_g && s1_first_j;
      f_last <= s1_valid && s1_last_g && s1_last;
    end
  end

  assign f_out = acc;

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  start_when_ready_a : assert property (
    @(posedge clk) disable iff (reset) start |-> ready
  );

  no_result_in_idle_a : assert property (
    @(posedge clk) disable iff (reset) f_out_j_enable |-> (state != S_IDLE)
  );

  // Host sizes stay inside the stores while busy
  sizes_in_range_a : assert property (
    @(posedge clk) disable iff (reset)
      (state != S_IDLE) |-> (size_n <= MAX_N && size_r <= MAX_R && size_n != '0)
  );

endmodule

`default_nettype wire
